// ==== design/pcs_tx_defs.svh ====
// Shared widths and scrambler constants for the 10GBASE-R PCS transmit path.
// Included by the RTL and by the testbench so both sides agree on the
// payload width and the scrambler start state.

`ifndef PCS_TX_DEFS_SVH
`define PCS_TX_DEFS_SVH

// Payload of one 66-bit block
`define PCS_DATA_W 64
`define PCS_KEEP_W 8 // One bit per byte
`define PCS_SYNC_W 2

// Scrambler polynomial x^58 + x^39 + 1
`define PCS_SCR_W 58
`define PCS_SCR_TAP 39

// State after reset
`define PCS_SCR_SEED {`PCS_SCR_W{1'b1}}

`endif

// ==== design/pcs_tx_pkg.sv ====
// Types for the PCS transmit path.
// Holds the input beat, the adapter word, the 66-bit block and the
// block type, control code and state encodings. Modules import it whole.

`include "pcs_tx_defs.svh"

package pcs_tx_pkg;

	typedef struct packed {
		logic [`PCS_DATA_W-1:0] data; // Byte 0 goes out first
		logic [`PCS_KEEP_W-1:0] keep; // Only looked at on the last beat
		logic                   last;
		logic                   err;
	} tx_beat_t;

	typedef struct packed {
		logic [`PCS_DATA_W-1:0] data;
		logic [`PCS_KEEP_W-1:0] keep;
		logic                   start; // Preamble word
		logic                   last;
		logic                   err;
		logic                   idle;
	} xgmii_word_t;

	typedef struct packed {
		logic [`PCS_SYNC_W-1:0] sync; // 01 data, 10 control
		logic [`PCS_DATA_W-1:0] payload;
	} pcs_block_t;

	typedef enum logic [7:0] {
		BT_CTRL    = 8'h1e,
		BT_START_0 = 8'h78,
		BT_TERM_0  = 8'h87,
		BT_TERM_1  = 8'h99,
		BT_TERM_2  = 8'haa,
		BT_TERM_3  = 8'hb4,
		BT_TERM_4  = 8'hcc,
		BT_TERM_5  = 8'hd2,
		BT_TERM_6  = 8'he1,
		BT_TERM_7  = 8'hff
	} blk_type_e;

	typedef enum logic [6:0] {
		CC_IDLE  = 7'h07,
		CC_ERROR = 7'h1e
	} ctrl_code_e;

	typedef enum logic [1:0] {ADP_IDLE, ADP_PREAMBLE, ADP_DATA, ADP_GAP} adp_state_e;

	typedef enum logic [1:0] {ENC_IDLE, ENC_DATA, ENC_END_DELAY} enc_state_e;

endpackage

// ==== design/tx_frame_adapter.sv ====
// Frame adapter in front of the 64b/66b encoder.
// Takes packet beats on a valid/ready stream, puts a preamble word in
// front of each packet and one idle word after it, and flags underruns
// as error words. The word output is registered.

`include "pcs_tx_defs.svh"

module tx_frame_adapter
	import pcs_tx_pkg::*;
(
	input  logic        clk,
	input  logic        nreset,
	input  tx_beat_t    beat_i,
	input  logic        beat_valid_i,
	output logic        beat_ready_o,
	output xgmii_word_t word_o
);

// 0x55 x6 then SFD, byte 0 is replaced by the start character
localparam logic [`PCS_DATA_W-1:0] PREAMBLE_DATA = 64'hd555_5555_5555_5500;

adp_state_e  state_q;
adp_state_e  state_next;
xgmii_word_t word_q;
xgmii_word_t word_next;
logic        accept;

// Ready while the preamble is out and during the packet body
assign beat_ready_o = (state_q == ADP_PREAMBLE) | (state_q == ADP_DATA);
assign accept       = beat_ready_o & beat_valid_i;

always_comb begin
	state_next     = state_q;
	word_next      = '0;
	word_next.idle = 1'b1; // Idle unless something else is sent

	case (state_q)
		ADP_IDLE: begin
			if (beat_valid_i) begin
				word_next.data  = PREAMBLE_DATA;
				word_next.keep  = '1;
				word_next.start = 1'b1;
				word_next.idle  = 1'b0;
				state_next      = ADP_PREAMBLE;
			end
		end
		ADP_PREAMBLE, ADP_DATA: begin
			if (accept) begin
				word_next.data = beat_i.data;
				word_next.keep = beat_i.keep;
				word_next.last = beat_i.last;
				word_next.err  = beat_i.err;
				word_next.idle = 1'b0;
				state_next     = beat_i.last ? ADP_GAP : ADP_DATA;
			end else begin
				// Underrun, the packet stays open
				word_next.err = 1'b1;
			end
		end
		ADP_GAP: state_next = ADP_IDLE; // One idle slot between packets
		default: state_next = ADP_IDLE;
	endcase
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		state_q <= ADP_IDLE;
		word_q  <= '0;
		word_q.idle <= 1'b1;
	end else begin
		state_q <= state_next;
		word_q  <= word_next;
	end
end

assign word_o = word_q;

endmodule

// ==== design/pcs_encoder_64b66b.sv ====
// 64b/66b encoder for the transmit path.
// Maps each adapter word to one block with its sync header. A last word
// with all eight bytes valid goes out as data, and the terminate block
// follows in the next slot, which the adapter always leaves idle.

`include "pcs_tx_defs.svh"

module pcs_encoder_64b66b
	import pcs_tx_pkg::*;
(
	input  logic        clk,
	input  logic        nreset,
	input  xgmii_word_t word_i,
	output pcs_block_t  blk_o
);

localparam logic [`PCS_SYNC_W-1:0] SYNC_DATA = 2'b01;
localparam logic [`PCS_SYNC_W-1:0] SYNC_CTRL = 2'b10;

enc_state_e              state_q;
enc_state_e              state_next;
logic                    keep_full;
logic [`PCS_KEEP_W-1:0]  eff_keep;
logic [`PCS_KEEP_W-1:0]  term_mask;
blk_type_e               term_type;
logic [`PCS_DATA_W-9:0]  term_body; // Everything above the type byte
pcs_block_t              blk_next;
pcs_block_t              blk_q;

assign keep_full = &word_i.keep;

// Delayed terminate carries no data bytes
assign eff_keep  = (state_q == ENC_END_DELAY) ? '0 : word_i.keep;
assign term_mask = eff_keep + 8'd1; // Keep is contiguous, so this is one-hot

always_comb begin
	case (term_mask)
		8'b0000_0001: term_type = BT_TERM_0;
		8'b0000_0010: term_type = BT_TERM_1;
		8'b0000_0100: term_type = BT_TERM_2;
		8'b0000_1000: term_type = BT_TERM_3;
		8'b0001_0000: term_type = BT_TERM_4;
		8'b0010_0000: term_type = BT_TERM_5;
		8'b0100_0000: term_type = BT_TERM_6;
		8'b1000_0000: term_type = BT_TERM_7;
		default:      term_type = BT_TERM_0;
	endcase
end

// Data bytes sit low, idle codes for the unused lanes sit at the top
always_comb begin
	term_body = '0;
	for (int i = 0; i < 7; i++) begin
		if (eff_keep[i]) begin
			term_body[8*i +: 8] = word_i.data[8*i +: 8];
		end else begin
			term_body[7 + 7*i +: 7] = CC_IDLE; // Lane i+1 code
		end
	end
end

always_comb begin
	blk_next.sync    = SYNC_CTRL;
	blk_next.payload = word_i.data;
	if (state_q == ENC_END_DELAY) begin
		blk_next.payload = {term_body, term_type};
	end else if (word_i.err) begin
		blk_next.payload = {{8{CC_ERROR}}, BT_CTRL}; // Replaces the whole block
	end else if (word_i.idle) begin
		blk_next.payload = {{8{CC_IDLE}}, BT_CTRL};
	end else if (word_i.start) begin
		blk_next.payload = {word_i.data[`PCS_DATA_W-1:8], BT_START_0};
	end else if (word_i.last && !keep_full) begin
		blk_next.payload = {term_body, term_type};
	end else begin
		blk_next.sync = SYNC_DATA;
	end
end

always_comb begin
	state_next = state_q;
	case (state_q)
		ENC_IDLE: begin
			if (word_i.start) state_next = ENC_DATA;
		end
		ENC_DATA: begin
			if (word_i.last) state_next = keep_full ? ENC_END_DELAY : ENC_IDLE;
		end
		default: state_next = ENC_IDLE; // Terminate sent, back to idle
	endcase
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		state_q <= ENC_IDLE;
	end else begin
		state_q <= state_next;
	end
end

always_ff @(posedge clk) begin
	blk_q <= blk_next;
end

assign blk_o = blk_q;

endmodule

// ==== design/pcs_scrambler.sv ====
// Self-synchronizing scrambler for the block payload.
// Payload bits go through LSB first. The sync header passes unchanged.
// One register stage on the output.

`include "pcs_tx_defs.svh"

module pcs_scrambler
	import pcs_tx_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  pcs_block_t blk_i,
	output pcs_block_t blk_o
);

logic [`PCS_SCR_W-1:0]  hist_q; // Bit 0 is the newest scrambled bit
logic [`PCS_SCR_W-1:0]  hist;
logic [`PCS_DATA_W-1:0] scr;
pcs_block_t             blk_q;

always_comb begin
	hist = hist_q;
	for (int i = 0; i < `PCS_DATA_W; i++) begin
		scr[i] = blk_i.payload[i] ^ hist[`PCS_SCR_TAP-1] ^ hist[`PCS_SCR_W-1];
		hist   = {hist[`PCS_SCR_W-2:0], scr[i]};
	end
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		hist_q <= `PCS_SCR_SEED;
	end else begin
		hist_q <= hist;
	end
end

always_ff @(posedge clk) begin
	blk_q.sync    <= blk_i.sync;
	blk_q.payload <= scr;
end

assign blk_o = blk_q;

endmodule

// ==== design/pcs_tx_top.sv ====
// Transmit PCS top level.
// Beats in on valid/ready, one scrambled 66-bit block out per clock,
// three cycles from an accepted beat to its block.

module pcs_tx_top
	import pcs_tx_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  tx_beat_t   beat_i,
	input  logic       beat_valid_i,
	output logic       beat_ready_o,
	output pcs_block_t blk_o
);

xgmii_word_t word; // Adapter to encoder
pcs_block_t  blk;  // Encoder to scrambler

tx_frame_adapter i_adapter (
	.clk          (clk),
	.nreset       (nreset),
	.beat_i       (beat_i),
	.beat_valid_i (beat_valid_i),
	.beat_ready_o (beat_ready_o),
	.word_o       (word)
);

pcs_encoder_64b66b i_encoder (
	.clk    (clk),
	.nreset (nreset),
	.word_i (word),
	.blk_o  (blk)
);

pcs_scrambler i_scrambler (
	.clk    (clk),
	.nreset (nreset),
	.blk_i  (blk),
	.blk_o  (blk_o)
);

endmodule

// ==== test/tb_clk_gen.sv ====
// Clock and reset source for the PCS transmit testbench.
// clk has a period of 8, nreset is held low for the first 8 rising edges.

module tb_clk_gen (
	output logic clk_o,
	output logic nreset_o
);

initial begin
	clk_o = 1'b0;
	forever #4 clk_o = ~clk_o;
end

initial begin
	nreset_o = 1'b0;
	repeat (8) @(posedge clk_o);
	#1 nreset_o = 1'b1; // Released just after the 8th edge
end

endmodule

// ==== test/pcs_tx_tb.sv ====
// Testbench for the transmit PCS top level.
// Sends a table of packets through pcs_tx_top, descrambles every output
// block with its own model and compares it with blocks built from the
// 64b/66b block rules. Ready is checked on every driven cycle.

`include "pcs_tx_defs.svh"

module pcs_tx_tb
	import pcs_tx_pkg::*;
();

localparam logic [6:0] IDLE_CODE  = 7'h07;
localparam logic [6:0] ERROR_CODE = 7'h1e;

logic       clk;
logic       nreset;
tx_beat_t   beat_i;
logic       beat_valid_i;
logic       beat_ready_o;
pcs_block_t blk_o;

pcs_block_t exp_q[$];  // One entry per driven cycle and three cycles ahead of blk_o
string      name_q[$];
tx_beat_t   beats[$];  // Beats of the packet being sent

// Packet table
string      pkt_name[$];
int         pkt_len[$];
int         err_idx[$];
int         gap_idx[$];
int         idle_after[$];
logic [7:0] exp_term[$];

int total_beats = 0;
int limit_cycles = 0;
int block_errs = 0;
int ready_errs = 0;
int blocks_checked = 0;

logic [`PCS_SCR_W-1:0]  rx_hist;
logic [`PCS_DATA_W-1:0] rx_data;
logic [`PCS_DATA_W-1:0] rx_shift;
pcs_block_t             rx_blk;
pcs_block_t             exp_blk;
string                  exp_name;

tb_clk_gen i_clk_gen (
	.clk_o    (clk),
	.nreset_o (nreset)
);

pcs_tx_top i_dut (
	.clk          (clk),
	.nreset       (nreset),
	.beat_i       (beat_i),
	.beat_valid_i (beat_valid_i),
	.beat_ready_o (beat_ready_o),
	.blk_o        (blk_o)
);

function automatic pcs_block_t ctrl_block(input logic [6:0] code);
	pcs_block_t b;
	b.sync    = 2'b10;
	b.payload = {{8{code}}, 8'h1e};
	return b;
endfunction

function automatic pcs_block_t data_block(input logic [63:0] data);
	pcs_block_t b;
	b.sync    = 2'b01;
	b.payload = data;
	return b;
endfunction

function automatic pcs_block_t start_block();
	pcs_block_t b;
	b.sync    = 2'b10;
	b.payload = {8'hd5, {6{8'h55}}, 8'h78}; // Preamble and SFD after the start type
	return b;
endfunction

// n data bytes after the type and idle codes packed down from the top
function automatic pcs_block_t term_block(input logic [7:0] t, input int n,
		input logic [63:0] data);
	pcs_block_t b;
	b.sync    = 2'b10;
	b.payload = {56'h0, t} | ((data & ({64{1'b1}} >> (64 - 8 * n))) << 8);
	for (int k = 0; k < 7 - n; k++) begin
		b.payload = b.payload | ({57'h0, IDLE_CODE} << (57 - 7 * k));
	end
	return b;
endfunction

function automatic tx_beat_t random_beat();
	tx_beat_t b;
	b.data = {$urandom, $urandom};
	b.keep = 8'hff;
	b.last = 1'b0;
	b.err  = 1'b0;
	return b;
endfunction

task automatic add_packet(input string name, input int len, input int err, input int gap,
		input int idle, input logic [7:0] term);
	pkt_name.push_back(name);
	pkt_len.push_back(len);
	err_idx.push_back(err);
	gap_idx.push_back(gap);
	idle_after.push_back(idle);
	exp_term.push_back(term);
	total_beats += (len + 7) / 8;
endtask

// Name, bytes, error beat, valid-low before beat, idle cycles after, terminate type
task automatic load_table();
	add_packet("full_8", 8, -1, -1, 4, 8'h87);
	add_packet("term_1", 9, -1, -1, 3, 8'h99);
	add_packet("term_2", 18, -1, -1, 3, 8'haa);
	add_packet("term_3", 27, -1, -1, 3, 8'hb4);
	add_packet("term_4", 36, -1, -1, 3, 8'hcc);
	add_packet("term_5", 45, -1, -1, 3, 8'hd2);
	add_packet("term_6", 54, -1, -1, 3, 8'he1);
	add_packet("term_7", 63, -1, -1, 3, 8'hff);
	add_packet("full_64", 64, -1, -1, 3, 8'h87);
	add_packet("err_beat", 40, 2, -1, 3, 8'h87);
	add_packet("underrun", 33, -1, 3, 3, 8'h99);
	add_packet("underrun_first", 16, -1, 0, 2, 8'h87);
	add_packet("b2b_a", 24, -1, -1, 0, 8'h87); // Valid stays high into the next packet
	add_packet("b2b_b", 13, -1, -1, 0, 8'hd2);
	add_packet("b2b_c", 7, -1, -1, 0, 8'hff);
	add_packet("single_byte", 1, -1, -1, 3, 8'h99);
endtask

task automatic make_beats(input int p);
	int       nb;
	tx_beat_t b;
	nb = (pkt_len[p] + 7) / 8;
	beats.delete();
	for (int i = 0; i < nb; i++) begin
		b = random_beat();
		if (i == nb - 1) begin
			b.last = 1'b1;
			b.keep = 8'hff >> (8 - (pkt_len[p] - 8 * i));
		end
		b.err = (i == err_idx[p]);
		beats.push_back(b);
	end
endtask

// Drives the inputs for one clock, checks ready and queues the block due three cycles later
task automatic drive_cycle(input logic valid, input tx_beat_t beat, input logic exp_ready,
		input pcs_block_t exp_b, input string name);
	@(posedge clk);
	#1;
	beat_valid_i = valid;
	beat_i       = beat;
	if (beat_ready_o !== exp_ready) begin
		$display("[FAIL] %s: beat_ready_o expected %0b actual %0b", name, exp_ready,
			beat_ready_o);
		ready_errs++;
	end
	exp_q.push_back(exp_b);
	name_q.push_back(name);
endtask

task automatic send_packet(input int p);
	int         nb;
	int         n;
	pcs_block_t e;
	nb = beats.size();
	n  = pkt_len[p] - 8 * (nb - 1); // Bytes in the last beat
	drive_cycle(1'b1, beats[0], 1'b0, start_block(), {pkt_name[p], "/start"});
	for (int i = 0; i < nb; i++) begin
		if (i == gap_idx[p])
			drive_cycle(1'b0, random_beat(), 1'b1, ctrl_block(ERROR_CODE),
				{pkt_name[p], "/underrun"});
		if (i == err_idx[p])
			e = ctrl_block(ERROR_CODE);
		else if (i == nb - 1 && n < 8)
			e = term_block(exp_term[p], n, beats[i].data);
		else
			e = data_block(beats[i].data);
		drive_cycle(1'b1, beats[i], 1'b1, e, pkt_name[p]);
	end
endtask

// Gap slot after a packet and then its idle cycles
task automatic end_packet(input int p, input logic next_valid, input tx_beat_t next_beat);
	pcs_block_t e;
	if (pkt_len[p] % 8 == 0)
		e = term_block(exp_term[p], 0, '0); // Delayed terminate
	else
		e = ctrl_block(IDLE_CODE);
	drive_cycle(next_valid, next_beat, 1'b0, e, {pkt_name[p], "/gap"});
	repeat (idle_after[p]) begin
		drive_cycle(1'b0, random_beat(), 1'b0, ctrl_block(IDLE_CODE), {pkt_name[p], "/idle"});
	end
endtask

initial begin
	beat_i       = '0;
	beat_valid_i = 1'b0;
	void'($urandom(32'h6cee_a3b6));
	load_table();
	limit_cycles = 20 * total_beats + 200;
	// Slots already in the pipeline when reset is released
	repeat (3) begin
		exp_q.push_back(ctrl_block(IDLE_CODE));
		name_q.push_back("reset");
	end
	wait (nreset === 1'b1);
	repeat (6) drive_cycle(1'b0, random_beat(), 1'b0, ctrl_block(IDLE_CODE), "after_reset");
	for (int p = 0; p < pkt_len.size(); p++) begin
		make_beats(p);
		if (p > 0)
			end_packet(p - 1, idle_after[p - 1] == 0, beats[0]);
		send_packet(p);
	end
	end_packet(pkt_len.size() - 1, 1'b0, random_beat());
	repeat (4) drive_cycle(1'b0, random_beat(), 1'b0, ctrl_block(IDLE_CODE), "tail");
	repeat (4) @(posedge clk); // Let the last slots drain
	$display("Checked %0d blocks: %0d block errors, %0d ready errors",
		blocks_checked, block_errs, ready_errs);
	if (block_errs + ready_errs == 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

// Descrambler and block checker fed from the first block after reset
initial begin
	rx_hist = `PCS_SCR_SEED;
	wait (nreset === 1'b1);
	@(posedge clk);
	forever begin
		@(negedge clk);
		rx_shift = blk_o.payload;
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			rx_data  = {rx_shift[0] ^ rx_hist[`PCS_SCR_TAP-1] ^ rx_hist[`PCS_SCR_W-1],
				rx_data[`PCS_DATA_W-1:1]};
			rx_hist  = {rx_hist[`PCS_SCR_W-2:0], rx_shift[0]}; // Scrambled bit history
			rx_shift = rx_shift >> 1;
		end
		rx_blk.sync    = blk_o.sync;
		rx_blk.payload = rx_data;
		if (exp_q.size() > 0) begin
			exp_blk  = exp_q.pop_front();
			exp_name = name_q.pop_front();
			blocks_checked++;
			if (rx_blk !== exp_blk) begin
				$display("[FAIL] %s: block expected %h actual %h", exp_name, exp_blk, rx_blk);
				block_errs++;
			end
		end
	end
end

initial begin
	wait (limit_cycles > 0);
	repeat (limit_cycles) @(posedge clk);
	$display("Timeout: the run did not finish within %0d cycles", limit_cycles);
	$display("SOME TESTS FAILED");
	$finish;
end

endmodule

// ==== compile.f ====
+incdir+design
design/pcs_tx_pkg.sv
design/tx_frame_adapter.sv
design/pcs_encoder_64b66b.sv
design/pcs_scrambler.sv
design/pcs_tx_top.sv
test/tb_clk_gen.sv
test/pcs_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PCS transmit testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log lacks the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --top-module pcs_tx_tb -Mdir obj_dir -f compile.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vpcs_tx_tb > "$log" 2>&1; then
	cat "$log"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$log"

if grep -q "ALL TESTS PASSED" "$log"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1
